//--- calc_pkg.sv
package calc_pkg;

    // Datapath widths
    localparam int OPERAND_W  = 16;              // Operands, products and display
    localparam int DIGIT_W    = 4;               // One BCD-style keypad digit
    localparam int MULT_STEPS = 16;              // One iteration per multiplier bit
    localparam int STEP_W     = $clog2(MULT_STEPS);

    // Value types
    typedef logic [OPERAND_W-1:0]        operand_t;  // Unsigned keyed operand
    typedef logic signed [OPERAND_W-1:0] result_t;   // Signed unit output and display
    typedef logic [DIGIT_W-1:0]          digit_t;    // Keypad digit
    typedef logic [2:0]                  op_sel_t;   // One-hot operator

    // Operator codes, one-hot
    localparam op_sel_t OP_ADD = 3'b001;
    localparam op_sel_t OP_SUB = 3'b010;
    localparam op_sel_t OP_MUL = 3'b100;

    // Control FSM states
    typedef enum logic [2:0] {
        ENTER_FIRST,                             // Keying first operand
        ENTER_SECOND,                            // Keying second operand
        LAUNCH,                                  // Start pulse to one unit
        WAIT_UNIT,                               // Waiting for finish
        SHOW_RESULT                              // Result latched, clear operands
    } calc_state_t;

    // Request seen by both arithmetic units
    typedef struct packed {
        operand_t a;                             // First operand
        operand_t b;                             // Second operand
        logic     sub;                           // Subtract when set
    } calc_req_t;

endpackage

//--- keypad_entry.sv
`timescale 1ns/1ps

module keypad_entry
    import calc_pkg::*;
(
    input  logic     clk,
    input  logic     nRST,
    input  digit_t   digit,                      // Keyed digit
    input  logic     take,                       // Accept digit this cycle
    input  logic     clear,                      // Restart the operand at zero
    output operand_t value                       // Operand built so far
);

    operand_t times_ten;
    operand_t next_value;

    // Multiply by ten as 8x plus 2x, wrapping at 16 bits
    assign times_ten  = (value << 3) + (value << 1);
    assign next_value = times_ten + operand_t'(digit);  // Digits above nine go in as given

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            value <= '0;
        end else if (clear) begin
            value <= '0;                         // Clear has priority over take
        end else if (take) begin
            value <= next_value;
        end
    end

endmodule

//--- calc_control.sv
`timescale 1ns/1ps

module calc_control
    import calc_pkg::*;
(
    input  logic      clk,
    input  logic      nRST,

    // Keypad side
    input  logic      read_input,                // Digit strobe from the keypad
    input  op_sel_t   operator_input,            // Operator selection
    input  logic      equal_input,               // Equal strobe
    input  operand_t  entry_value,               // Operand from the entry block
    output logic      take,                      // Let the entry block take a digit
    output logic      clear,                     // Restart the entry block

    // Arithmetic unit side
    output calc_req_t req,
    output logic      start_add,
    output logic      start_mult,
    input  result_t   add_result,
    input  logic      add_finish,
    input  result_t   mult_result,
    input  logic      mult_finish,

    // Display side
    output logic      complete,                  // One-cycle done pulse
    output result_t   display_output
);

    calc_state_t state, state_next;

    operand_t operand_a;                         // First operand, held after operator
    operand_t operand_b;                         // Second operand, held after equal
    op_sel_t  op_q;                              // Latched operator

    logic    op_valid;
    logic    take_op;                            // Operator accepted this cycle
    logic    take_eq;                            // Equal accepted this cycle
    logic    unit_done;
    result_t unit_result;

    // Only the three one-hot codes count as an operator
    assign op_valid = (operator_input == OP_ADD) ||
                      (operator_input == OP_SUB) ||
                      (operator_input == OP_MUL);

    assign take_op = (state == ENTER_FIRST) && op_valid;
    assign take_eq = (state == ENTER_SECOND) && equal_input;

    // Digits only flow while an operand is being keyed
    assign take  = read_input && ((state == ENTER_FIRST) || (state == ENTER_SECOND));
    assign clear = take_op || take_eq;           // Entry restarts at the same edge

    assign req.a   = operand_a;
    assign req.b   = operand_b;
    assign req.sub = (op_q == OP_SUB);

    // Each start decodes its own bits of the latched operator
    assign start_add  = (state == LAUNCH) && ((op_q & (OP_ADD | OP_SUB)) != '0);
    assign start_mult = (state == LAUNCH) && ((op_q & OP_MUL) != '0);

    // Listen to the launched unit only
    always_comb begin
        if (op_q == OP_MUL) begin
            unit_done   = mult_finish;
            unit_result = mult_result;
        end else begin
            unit_done   = add_finish;
            unit_result = add_result;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ENTER_FIRST: begin
                if (take_op) begin
                    state_next = ENTER_SECOND;
                end
            end
            ENTER_SECOND: begin
                if (take_eq) begin
                    state_next = LAUNCH;
                end
            end
            LAUNCH: begin
                state_next = WAIT_UNIT;          // Start lasts a single cycle
            end
            WAIT_UNIT: begin
                if (unit_done) begin
                    state_next = SHOW_RESULT;
                end
            end
            SHOW_RESULT: begin
                state_next = ENTER_FIRST;
            end
            default: begin
                state_next = ENTER_FIRST;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state <= ENTER_FIRST;
        end else begin
            state <= state_next;
        end
    end

    // Operand and operator buffer
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            operand_a <= '0;
            operand_b <= '0;
            op_q      <= OP_ADD;
        end else if (state == SHOW_RESULT) begin
            operand_a <= '0;                     // Next calculation starts from zero
            operand_b <= '0;
        end else begin
            if (take_op) begin
                operand_a <= entry_value;
                op_q      <= operator_input;     // No need to hold the key until equal
            end
            if (take_eq) begin
                operand_b <= entry_value;
            end
        end
    end

    // Result latch and done pulse
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            complete       <= 1'b0;
            display_output <= '0;
        end else begin
            complete <= (state == WAIT_UNIT) && unit_done;
            if ((state == WAIT_UNIT) && unit_done) begin
                display_output <= unit_result;
            end
        end
    end

    // Only one unit may be started at a time
    a_one_start: assert property (
        @(posedge clk) disable iff (!nRST)
        !(start_add && start_mult)
    ) else $error("start_add and start_mult high together");

    a_complete_pulse: assert property (
        @(posedge clk) disable iff (!nRST)
        complete |=> !complete
    ) else $error("complete held longer than one cycle");

endmodule

//--- add_sub_unit.sv
`timescale 1ns/1ps

module add_sub_unit
    import calc_pkg::*;
(
    input  logic      clk,
    input  logic      nRST,
    input  calc_req_t req,                       // Operands and subtract flag
    input  logic      start,                     // One-cycle launch
    output result_t   result,                    // Held until the next start
    output logic      finish                     // One cycle after start
);

    result_t sum;
    result_t diff;

    // Two's complement wraps at 16 bits either way
    assign sum  = result_t'(req.a + req.b);
    assign diff = result_t'(req.a - req.b);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            result <= req.sub ? diff : sum;
        end
    end

    // Control pulses start once, so finish must be a single pulse too
    a_finish_after_start: assert property (
        @(posedge clk) disable iff (!nRST)
        start |=> finish ##1 !finish
    ) else $error("add_sub_unit finish did not follow start by one cycle");

endmodule

//--- shift_add_multiplier.sv
`timescale 1ns/1ps

module shift_add_multiplier
    import calc_pkg::*;
(
    input  logic      clk,
    input  logic      nRST,
    input  calc_req_t req,                       // sub is not used here
    input  logic      start,                     // One-cycle launch
    output result_t   result,                    // Low half of the product
    output logic      finish                     // MULT_STEPS cycles after start
);

    operand_t          mcand;                    // Multiplicand, shifted left each step
    operand_t          mplier;                   // Multiplier, shifted right each step
    operand_t          acc;                      // Running partial sum
    operand_t          partial;
    logic [STEP_W-1:0] step;
    logic              busy;
    logic              last_step;

    assign partial   = mplier[0] ? mcand : '0;
    assign last_step = (step == STEP_W'(MULT_STEPS - 1));
    assign result    = result_t'(acc);

    // Step sequencing
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            step   <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                step <= STEP_W'(1);              // Bit zero is done at load
            end else if (busy) begin
                step <= step + 1'b1;
                if (last_step) begin
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end
            end
        end
    end

    // Shift-add datapath
    always_ff @(posedge clk) begin
        if (start) begin
            acc    <= req.b[0] ? req.a : '0;     // First partial product at load
            mcand  <= req.a << 1;
            mplier <= req.b >> 1;
        end else if (busy) begin
            acc    <= acc + partial;             // Bits above 15 fall away
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Control must wait for finish before a new launch
    a_no_start_busy: assert property (
        @(posedge clk) disable iff (!nRST)
        start |-> !busy
    ) else $error("multiplier started while busy");

endmodule

//--- calc_top.sv
`timescale 1ns/1ps

module calc_top
    import calc_pkg::*;
(
    input  logic    clk,
    input  logic    nRST,
    input  digit_t  keypad_input,                // Digit on the keypad
    input  logic    read_input,                  // Digit strobe
    input  op_sel_t operator_input,              // One-hot operator
    input  logic    equal_input,                 // Equal strobe
    output logic    complete,                    // Result ready pulse
    output result_t display_output               // Signed result
);

    logic      take;
    logic      clear;
    operand_t  entry_value;
    calc_req_t req;
    logic      start_add;
    logic      start_mult;
    result_t   add_result;
    logic      add_finish;
    result_t   mult_result;
    logic      mult_finish;

    keypad_entry i_entry (
        .clk   (clk),
        .nRST  (nRST),
        .digit (keypad_input),
        .take  (take),
        .clear (clear),
        .value (entry_value)
    );

    calc_control i_control (
        .clk            (clk),
        .nRST           (nRST),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .entry_value    (entry_value),
        .take           (take),
        .clear          (clear),
        .req            (req),
        .start_add      (start_add),
        .start_mult     (start_mult),
        .add_result     (add_result),
        .add_finish     (add_finish),
        .mult_result    (mult_result),
        .mult_finish    (mult_finish),
        .complete       (complete),
        .display_output (display_output)
    );

    add_sub_unit i_add_sub (
        .clk    (clk),
        .nRST   (nRST),
        .req    (req),
        .start  (start_add),
        .result (add_result),
        .finish (add_finish)
    );

    shift_add_multiplier i_mult (
        .clk    (clk),
        .nRST   (nRST),
        .req    (req),
        .start  (start_mult),
        .result (mult_result),
        .finish (mult_finish)
    );

endmodule

//--- tb_calc.sv
`timescale 1ns/1ps

module tb_calc
    import calc_pkg::*;
();

    localparam int CLK_PERIOD       = 40;
    localparam int RESET_CYCLES     = 8;
    localparam int NUM_ENTRIES      = 11;
    localparam int WAIT_LIMIT       = 40;     // Cycles allowed from equal to complete
    localparam int CYCLES_PER_ENTRY = 60;

    logic    clk;
    logic    nRST;
    digit_t  keypad_input;
    logic    read_input;
    op_sel_t operator_input;
    logic    equal_input;
    logic    complete;
    result_t display_output;

    // Stimulus table, one index per calculation
    string   first_str  [NUM_ENTRIES];
    op_sel_t op_code    [NUM_ENTRIES];
    string   second_str [NUM_ENTRIES];
    result_t expected   [NUM_ENTRIES];
    op_sel_t bad_code   [NUM_ENTRIES];   // Invalid operator keyed inside the first operand
    int      bad_pos    [NUM_ENTRIES];   // Digits keyed before the invalid code

    int complete_count;                  // Pulses seen on complete
    int pulses_seen;                     // Pulses the entry loop waited for
    int pass_count;
    int fail_count;

    calc_top i_dut (
        .clk            (clk),
        .nRST           (nRST),
        .keypad_input   (keypad_input),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .complete       (complete),
        .display_output (display_output)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Count every high cycle of complete, away from the driving edge
    always @(negedge clk) begin
        if (!nRST) begin
            complete_count <= 0;
        end else if (complete) begin
            complete_count <= complete_count + 1;
        end
    end

    task automatic set_entry(input int idx, input string a, input op_sel_t op,
                             input string b, input int exp_val,
                             input op_sel_t bad, input int pos);
        first_str[idx]  = a;
        op_code[idx]    = op;
        second_str[idx] = b;
        expected[idx]   = result_t'(exp_val);    // Wraps to 16-bit signed
        bad_code[idx]   = bad;
        bad_pos[idx]    = pos;
    endtask

    task automatic load_table();
        set_entry(0,  "123",   OP_ADD, "456", 579,    3'b000, 0);
        set_entry(1,  "7",     OP_SUB, "25",  -18,    3'b000, 0);
        set_entry(2,  "300",   OP_MUL, "300", 24464,  3'b000, 0);  // 90000 less 65536
        set_entry(3,  "12",    OP_MUL, "11",  132,    3'b011, 1);  // Two bits set
        set_entry(4,  "50",    OP_SUB, "8",   42,     3'b111, 2);
        set_entry(5,  "65535", OP_ADD, "1",   0,      3'b000, 0);  // Wraps to zero
        set_entry(6,  "255",   OP_MUL, "257", -1,     3'b000, 0);  // 65535 read as signed
        set_entry(7,  "40000", OP_ADD, "0",   -25536, 3'b000, 0);
        set_entry(8,  "5",     OP_ADD, "6",   11,     3'b110, 0);
        set_entry(9,  "99",    OP_MUL, "0",   0,      3'b000, 0);
        set_entry(10, "1000",  OP_SUB, "1",   999,    3'b000, 0);
    endtask

    function automatic string op_name(input op_sel_t op);
        string name;
        case (op)
            OP_ADD:  name = "+";
            OP_SUB:  name = "-";
            OP_MUL:  name = "*";
            default: name = "?";
        endcase
        return name;
    endfunction

    // Inputs change 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic key_digit(input digit_t d);
        next_cycle();
        keypad_input = d;
        read_input   = 1'b1;
        next_cycle();
        read_input   = 1'b0;
    endtask

    task automatic apply_operator(input op_sel_t op);
        next_cycle();
        operator_input = op;
        next_cycle();
        operator_input = 3'b000;
    endtask

    task automatic press_equal();
        next_cycle();
        equal_input = 1'b1;
        next_cycle();
        equal_input = 1'b0;
    endtask

    // Keys a digit string, with an optional invalid operator after pos digits
    task automatic key_operand(input string s, input op_sel_t bad, input int pos);
        for (int i = 0; i <= s.len(); i++) begin
            if (i == pos && bad != 3'b000) begin
                apply_operator(bad);
            end
            if (i < s.len()) begin
                key_digit(digit_t'(s.getc(i) - 8'd48));
            end
        end
    endtask

    task automatic wait_complete(output bit seen);
        int waited;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
            if (complete) begin
                seen = 1'b1;
            end
        end
    endtask

    task automatic check_reset_state();
        next_cycle();
        if (complete !== 1'b0 || display_output !== result_t'(0)) begin
            $display("error at %0t: after reset complete=%b display_output=%0d, expected 0 and 0",
                     $time, complete, display_output);
            fail_count++;
        end else begin
            $display("reset: complete low, display_output zero, ok");
            pass_count++;
        end
    endtask

    task automatic run_entry(input int idx);
        bit seen;
        key_operand(first_str[idx], bad_code[idx], bad_pos[idx]);
        apply_operator(op_code[idx]);
        key_operand(second_str[idx], 3'b000, 0);
        press_equal();
        wait_complete(seen);
        if (!seen) begin
            $display("entry %0d: no complete pulse within %0d cycles after equal",
                     idx, WAIT_LIMIT);
            fail_count++;
        end else begin
            pulses_seen++;
            if (display_output !== expected[idx]) begin
                $display("error at %0t: entry %0d %s %s %s gave %0d, expected %0d", $time, idx,
                         first_str[idx], op_name(op_code[idx]), second_str[idx],
                         display_output, expected[idx]);
                fail_count++;
            end else begin
                $display("entry %0d: %s %s %s = %0d ok", idx, first_str[idx],
                         op_name(op_code[idx]), second_str[idx], display_output);
                pass_count++;
            end
            next_cycle();                        // Control is back in ENTER_FIRST
            if (complete_count != pulses_seen) begin
                $display("entry %0d: complete pulsed %0d times so far, expected %0d",
                         idx, complete_count, pulses_seen);
                fail_count++;
            end
        end
    endtask

    initial begin
        nRST           = 1'b0;
        keypad_input   = '0;
        read_input     = 1'b0;
        operator_input = 3'b000;
        equal_input    = 1'b0;
        pulses_seen    = 0;
        pass_count     = 0;
        fail_count     = 0;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        nRST = 1'b1;
        check_reset_state();
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(i);
        end
        repeat (3) next_cycle();                 // Catch any late stray pulse
        if (complete_count != pulses_seen) begin
            $display("complete pulsed %0d times in total, expected %0d",
                     complete_count, pulses_seen);
            fail_count++;
        end
        $display("%0d checks passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Sized from the table length with room per entry
    initial begin
        #((NUM_ENTRIES * CYCLES_PER_ENTRY + RESET_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired at %0t before the entry loop finished", $time);
        $display("Verification failed");
        $finish;
    end

endmodule

//--- project.f
calc_pkg.sv
keypad_entry.sv
calc_control.sv
add_sub_unit.sv
shift_add_multiplier.sv
calc_top.sv
tb_calc.sv

//--- Makefile
SIM_LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/sim: project.f *.sv
	verilator --binary --timing --top-module tb_calc -f project.f -o sim

run: obj_dir/sim
	./obj_dir/sim | tee $(SIM_LOG)
	grep -qx "Verification passed" $(SIM_LOG)

lint:
	verilator --lint-only -Wall --timing --top-module calc_top -f project.f

clean:
	rm -rf obj_dir $(SIM_LOG)
